// File: Makefile
# Verilator build, run and lint for the MEM/WB pipeline project.

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up in the simulator output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/data_ram.sv
`timescale 1ns/10ps

module data_ram import rv_mem_pkg::*; #(
    parameter int read_latency = dmem_read_latency
) (
    input  logic                      I_sys_clk,
    input  logic                      I_rst,
    input  dmem_req_t                 dmem_req,
    output logic [dmem_data_bits-1:0] rdata,
    output logic                      rvalid
);

    logic [dmem_data_bits-1:0] mem [dmem_words];
    logic [dmem_idx_bits-1:0]  idx;
    logic                      rd_fire;

    // stage 0 is loaded on the accept edge, the last stage drives the outputs.
    logic [dmem_data_bits-1:0] pipe_data [read_latency+1];
    logic [read_latency:0]     pipe_valid;

    assign idx     = dmem_req.addr[dmem_off_bits +: dmem_idx_bits];
    assign rd_fire = dmem_req.en && !dmem_req.we;

    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (dmem_req.en && dmem_req.we) begin
            for (int b = 0; b < dmem_strb_bits; b++) begin
                if (dmem_req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge I_sys_clk) begin
        pipe_data[0] <= mem[idx];                 // read data moves along with its valid tag.
        for (int s = 1; s <= read_latency; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[read_latency-1:0], rd_fire};
        end
    end

    assign rdata  = pipe_data[read_latency];
    assign rvalid = pipe_valid[read_latency];     // one pulse per accepted read.

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/10ps

module mem_stage import rv_mem_pkg::*; import rv_pipe_pkg::*; (
    input  logic        I_sys_clk,
    input  logic        I_rst,
    input  logic        ex_mem_valid,
    output logic        ex_mem_allowin,
    input  ex_mem_bus_t ex_mem_bus,
    output logic        mem_wb_valid,
    input  logic        mem_wb_allowin,
    output mem_wb_bus_t mem_wb_bus,
    output dmem_req_t   dmem_req
);

    logic        valid_q;
    ex_mem_bus_t bus_q;
    logic        leave;
    logic        is_load;
    logic        is_store;
    logic        ld_signed;
    logic [7:0]  size_mask;
    logic [2:0]  byte_off;
    logic [7:0]  lane_strb;
    logic [xlen-1:0] store_lanes;

    assign leave          = valid_q && mem_wb_allowin;   // the held item moves on this cycle.
    assign ex_mem_allowin = !valid_q || mem_wb_allowin;
    assign mem_wb_valid   = valid_q;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (ex_mem_allowin) begin
            valid_q <= ex_mem_valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (ex_mem_valid && ex_mem_allowin) begin
            bus_q <= ex_mem_bus;
        end
    end

    assign is_load   = bus_q.mem_op inside {mem_lb, mem_lh, mem_lw, mem_ld,
                                            mem_lbu, mem_lhu, mem_lwu};
    assign is_store  = bus_q.mem_op inside {mem_sb, mem_sh, mem_sw, mem_sd};
    assign ld_signed = bus_q.mem_op inside {mem_lb, mem_lh, mem_lw};

    always_comb begin
        case (bus_q.mem_op)
            mem_lb, mem_lbu, mem_sb: size_mask = 8'h01;
            mem_lh, mem_lhu, mem_sh: size_mask = 8'h03;
            mem_lw, mem_lwu, mem_sw: size_mask = 8'h0f;
            mem_ld, mem_sd:          size_mask = 8'hff;
            default:                 size_mask = 8'h00;
        endcase
    end

    // A wider access clears the low offset bits, so misaligned addresses round down.
    assign byte_off  = bus_q.addr[2:0] & ~{size_mask[4], size_mask[2], size_mask[1]};
    assign lane_strb = size_mask << byte_off;

    always_comb begin
        case (size_mask)
            8'h01:   store_lanes = {8{bus_q.store_data[7:0]}};
            8'h03:   store_lanes = {4{bus_q.store_data[15:0]}};
            8'h0f:   store_lanes = {2{bus_q.store_data[31:0]}};
            default: store_lanes = bus_q.store_data;
        endcase
    end

    always_comb begin
        mem_wb_bus.pc        = bus_q.pc;
        mem_wb_bus.rstrb     = is_load ? {ld_signed, size_mask} : 9'h000; // lanes of the result.
        mem_wb_bus.shamt     = byte_off;
        mem_wb_bus.alu_out   = bus_q.alu_out;
        mem_wb_bus.reg_wen   = bus_q.reg_wen;
        mem_wb_bus.rd_addr   = bus_q.rd_addr;
        mem_wb_bus.regin_sel = bus_q.regin_sel;
        mem_wb_bus.inst      = bus_q.inst;
        mem_wb_bus.bubble    = bus_q.bubble;
    end

    always_comb begin
        dmem_req.en    = leave && (is_load || is_store); // sent once, on the transfer cycle.
        dmem_req.we    = is_store;
        dmem_req.addr  = {bus_q.addr[xlen-1:3], 3'b000};
        dmem_req.wdata = store_lanes;
        dmem_req.wstrb = is_store ? lane_strb : 8'h00;
    end

endmodule

// File: hw/mem_wb_reg.sv
`timescale 1ns/10ps

module mem_wb_reg import rv_pipe_pkg::*; (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  logic            mem_wb_valid,
    output logic            mem_wb_allowin,
    input  mem_wb_bus_t     mem_wb_bus,
    input  logic [xlen-1:0] mem_data,
    input  logic            mem_data_valid,
    output logic            wb_valid,
    output mem_wb_bus_t     wb_bus,
    output logic [xlen-1:0] wb_mem_data
);

    logic        valid_q;
    mem_wb_bus_t bus_q;
    logic        wait_mem;

    // A held load may not leave before its data arrives.
    assign wait_mem       = bus_q.regin_sel[1];
    assign wb_valid       = valid_q && (!wait_mem || mem_data_valid);
    assign mem_wb_allowin = !valid_q || wb_valid;  // write-back always accepts.

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (mem_wb_allowin) begin
            valid_q <= mem_wb_valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (mem_wb_allowin && mem_wb_valid) begin
            bus_q <= mem_wb_bus;
        end
    end

    assign wb_bus      = bus_q;
    assign wb_mem_data = mem_data; // load data is used in the cycle rvalid is high.

endmodule

// File: hw/mem_wb_top.sv
`timescale 1ns/10ps

module mem_wb_top import rv_mem_pkg::*; import rv_pipe_pkg::*; (
    input  logic        I_sys_clk,
    input  logic        I_rst,
    input  logic        ex_mem_valid,
    output logic        ex_mem_allowin,
    input  ex_mem_bus_t ex_mem_bus,
    output logic        commit_valid,
    output wb_commit_t  commit
);

    logic            mem_wb_valid;
    logic            mem_wb_allowin;
    mem_wb_bus_t     mem_wb_bus;
    dmem_req_t       dmem_req;
    logic [xlen-1:0] dmem_rdata;
    logic            dmem_rvalid;
    logic            wb_valid;
    mem_wb_bus_t     wb_bus;
    logic [xlen-1:0] wb_mem_data;

    mem_stage u_mem_stage (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .ex_mem_valid   (ex_mem_valid),
        .ex_mem_allowin (ex_mem_allowin),
        .ex_mem_bus     (ex_mem_bus),
        .mem_wb_valid   (mem_wb_valid),
        .mem_wb_allowin (mem_wb_allowin),
        .mem_wb_bus     (mem_wb_bus),
        .dmem_req       (dmem_req)
    );

    data_ram #(.read_latency(dmem_read_latency)) u_data_ram (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .dmem_req  (dmem_req),
        .rdata     (dmem_rdata),
        .rvalid    (dmem_rvalid)
    );

    mem_wb_reg u_mem_wb_reg (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .mem_wb_valid   (mem_wb_valid),
        .mem_wb_allowin (mem_wb_allowin),
        .mem_wb_bus     (mem_wb_bus),
        .mem_data       (dmem_rdata),
        .mem_data_valid (dmem_rvalid),
        .wb_valid       (wb_valid),
        .wb_bus         (wb_bus),
        .wb_mem_data    (wb_mem_data)
    );

    wb_stage u_wb_stage (
        .wb_valid     (wb_valid),
        .wb_bus       (wb_bus),
        .wb_mem_data  (wb_mem_data),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// File: hw/rv_mem_pkg.sv
package rv_mem_pkg;

    localparam int dmem_words        = 256;                   // doublewords in the data RAM.
    localparam int dmem_idx_bits     = $clog2(dmem_words);    // doubleword index width.
    localparam int dmem_data_bits    = 64;                    // one doubleword per RAM entry.
    localparam int dmem_strb_bits    = dmem_data_bits / 8;    // one strobe per byte lane.
    localparam int dmem_off_bits     = $clog2(dmem_strb_bits); // byte offset inside a word.
    localparam int dmem_addr_bits    = 64;                    // byte address width.
    localparam int dmem_read_latency = 2;                     // edges from accept to rvalid.

    // Memory opcodes of the execute bundle.
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_ld   = 4'd4,
        mem_lbu  = 4'd5,
        mem_lhu  = 4'd6,
        mem_lwu  = 4'd7,
        mem_sb   = 4'd8,
        mem_sh   = 4'd9,
        mem_sw   = 4'd10,
        mem_sd   = 4'd11
    } mem_op_e;

    // One data RAM request, valid for a single cycle.
    typedef struct packed {
        logic                      en;    // request is present.
        logic                      we;    // store when set, load otherwise.
        logic [dmem_addr_bits-1:0] addr;  // doubleword aligned byte address.
        logic [dmem_data_bits-1:0] wdata; // store data already placed in its lanes.
        logic [dmem_strb_bits-1:0] wstrb; // byte lanes written by a store.
    } dmem_req_t;

endpackage

// File: hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

    localparam int xlen          = 64; // integer data path width.
    localparam int reg_addr_bits = 5;  // 32 architectural registers.
    localparam int inst_bits     = 32; // instruction word width.

    // Write-back result source. Only the mem value has bit 1 set, which marks a load.
    typedef enum logic [2:0] {
        regin_none = 3'b000,
        regin_alu  = 3'b001,
        regin_mem  = 3'b010,
        regin_pc4  = 3'b100
    } regin_sel_e;

    typedef struct packed {
        logic [xlen-1:0]          pc;
        rv_mem_pkg::mem_op_e      mem_op;
        logic [xlen-1:0]          addr;       // effective byte address.
        logic [xlen-1:0]          store_data; // store value in its low bits.
        logic [xlen-1:0]          alu_out;
        logic                     reg_wen;
        logic [reg_addr_bits-1:0] rd_addr;
        regin_sel_e               regin_sel;
        logic [inst_bits-1:0]     inst;
        logic                     bubble;     // inserted nop, never writes a register.
    } ex_mem_bus_t;

    typedef struct packed {
        logic [xlen-1:0]          pc;
        logic [8:0]               rstrb;      // bit 8 is the signed flag, 7:0 the result lanes.
        logic [2:0]               shamt;      // byte offset of the load inside the word.
        logic [xlen-1:0]          alu_out;
        logic                     reg_wen;
        logic [reg_addr_bits-1:0] rd_addr;
        regin_sel_e               regin_sel;
        logic [inst_bits-1:0]     inst;
        logic                     bubble;
    } mem_wb_bus_t;

    typedef struct packed {
        logic [xlen-1:0]          pc;
        logic [reg_addr_bits-1:0] rd_addr;
        logic                     wen;
        logic [xlen-1:0]          wdata;
        logic [inst_bits-1:0]     inst;
    } wb_commit_t;

endpackage

// File: hw/wb_stage.sv
`timescale 1ns/10ps

module wb_stage import rv_pipe_pkg::*; (
    input  logic            wb_valid,
    input  mem_wb_bus_t     wb_bus,
    input  logic [xlen-1:0] wb_mem_data,
    output logic            commit_valid,
    output wb_commit_t      commit
);

    logic [xlen-1:0] shifted;
    logic [xlen-1:0] lane_mask;
    logic            msb;
    logic            sign;
    logic [xlen-1:0] load_val;
    logic [xlen-1:0] wdata;

    assign shifted = wb_mem_data >> {wb_bus.shamt, 3'b000}; // loaded bytes move to bit 0.

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lane_mask[8*i +: 8] = {8{wb_bus.rstrb[i]}};
        end
    end

    always_comb begin
        case (wb_bus.rstrb[7:0])
            8'h01:   msb = shifted[7];
            8'h03:   msb = shifted[15];
            8'h0f:   msb = shifted[31];
            default: msb = shifted[63];
        endcase
    end

    assign sign     = wb_bus.rstrb[8] && msb;
    // bits above the access are filled with the sign, or zero for unsigned loads.
    assign load_val = (shifted & lane_mask) | ({xlen{sign}} & ~lane_mask);

    always_comb begin
        case (wb_bus.regin_sel)
            regin_alu: wdata = wb_bus.alu_out;
            regin_mem: wdata = load_val;
            regin_pc4: wdata = wb_bus.pc + xlen'(4);
            default:   wdata = '0;
        endcase
    end

    assign commit_valid   = wb_valid;
    assign commit.pc      = wb_bus.pc;
    assign commit.rd_addr = wb_bus.rd_addr;
    assign commit.wen     = wb_bus.reg_wen && (wb_bus.rd_addr != '0) && !wb_bus.bubble; // x0 stays zero.
    assign commit.wdata   = wdata;
    assign commit.inst    = wb_bus.inst;

endmodule

// File: list.f
hw/rv_mem_pkg.sv
hw/rv_pipe_pkg.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/mem_wb_reg.sv
hw/wb_stage.sv
hw/mem_wb_top.sv
test/tb_mem_wb.sv

// File: test/tb_mem_wb.sv
`timescale 1ns/10ps

module tb_mem_wb
    import rv_mem_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int timeout_cycles = 100;

    logic        I_sys_clk;
    logic        I_rst;
    logic        ex_mem_valid;
    logic        ex_mem_allowin;
    ex_mem_bus_t ex_mem_bus;
    logic        commit_valid;
    wb_commit_t  commit;

    logic [31:0] lfsr_state;
    logic [7:0]  model_mem [2048];  // byte image of the 256 doubleword RAM.
    wb_commit_t  want_q [$];
    int          due_q [$];         // commit cycle of a timed item, or -1.
    int          cycle = 0;
    logic        stall_seen;

    mem_wb_top dut (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .ex_mem_valid   (ex_mem_valid),
        .ex_mem_allowin (ex_mem_allowin),
        .ex_mem_bus     (ex_mem_bus),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

    always #2 I_sys_clk = ~I_sys_clk;

    always @(posedge I_sys_clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] want);
        if (got !== want) begin
            abort_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    // galois shift register that steps once per bit.
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            r = {r[62:0], b};
        end
        return r;
    endfunction

    function automatic bit is_load_op(mem_op_e op);
        return op inside {mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu};
    endfunction

    // expected commit of one item. Stores update the byte image as they are sent.
    function automatic wb_commit_t model_commit(ex_mem_bus_t b);
        wb_commit_t  c;
        int          size;
        logic [10:0] base;
        logic [63:0] val;
        case (b.mem_op)
            mem_lb, mem_lbu, mem_sb: size = 1;
            mem_lh, mem_lhu, mem_sh: size = 2;
            mem_lw, mem_lwu, mem_sw: size = 4;
            mem_ld, mem_sd:          size = 8;
            default:                 size = 0;
        endcase
        base = b.addr[10:0] & ~11'(size - 1); // natural alignment of the access.
        val  = '0;
        if (b.mem_op inside {mem_sb, mem_sh, mem_sw, mem_sd}) begin
            for (int i = 0; i < size; i++) begin
                model_mem[base + 11'(i)] = b.store_data[8*i +: 8];
            end
        end
        if (is_load_op(b.mem_op)) begin
            for (int i = 0; i < 8; i++) begin
                if (i < size) begin
                    val[8*i +: 8] = model_mem[base + 11'(i)]; // little endian.
                end else if ((b.mem_op inside {mem_lb, mem_lh, mem_lw}) && val[8*size-1]) begin
                    val[8*i +: 8] = 8'hff;
                end
            end
        end
        case (b.regin_sel)
            regin_alu: c.wdata = b.alu_out;
            regin_mem: c.wdata = val;
            regin_pc4: c.wdata = b.pc + 64'd4;
            default:   c.wdata = '0;
        endcase
        c.pc      = b.pc;
        c.rd_addr = b.rd_addr;
        c.wen     = b.reg_wen && (b.rd_addr != '0) && !b.bubble;
        c.inst    = b.inst;
        return c;
    endfunction

    function automatic ex_mem_bus_t build_item(mem_op_e op, logic [63:0] addr, regin_sel_e sel);
        ex_mem_bus_t b;
        b.pc         = rand_bits(62) << 2;
        b.mem_op     = op;
        b.addr       = addr;
        b.store_data = rand_bits(64);
        b.alu_out    = rand_bits(64);
        b.reg_wen    = !(op inside {mem_sb, mem_sh, mem_sw, mem_sd});
        b.rd_addr    = 5'(rand_bits(5));
        b.regin_sel  = sel;
        b.inst       = 32'(rand_bits(32));
        b.bubble     = 1'b0;
        return b;
    endfunction

    function automatic ex_mem_bus_t random_item();
        ex_mem_bus_t b;
        logic [2:0]  kind;
        logic [63:0] addr;
        kind = 3'(rand_bits(3));
        addr = rand_bits(7); // loads often meet earlier stores within 16 doublewords.
        case (kind)
            3'd0, 3'd1: b = build_item(mem_none, addr, regin_alu);
            3'd2:       b = build_item(mem_none, addr, regin_pc4);
            3'd3, 3'd4: b = build_item(mem_op_e'(4'(rand_bits(3) % 7 + 1)), addr, regin_mem);
            3'd5, 3'd6: b = build_item(mem_op_e'(4'(rand_bits(2) + 8)), addr, regin_none);
            default: begin
                b        = build_item(mem_none, addr, regin_alu);
                b.bubble = 1'b1;
            end
        endcase
        return b;
    endfunction

    task automatic next_cycle();
        @(posedge I_sys_clk);
        #1;
    endtask

    // drive one item and hold it until the stage takes it.
    task automatic send_item(ex_mem_bus_t b, bit timed);
        int tries;
        int lat;
        tries        = 0;
        ex_mem_bus   = b;
        ex_mem_valid = 1'b1;
        @(negedge I_sys_clk);
        while (!ex_mem_allowin && tries < timeout_cycles) begin
            stall_seen = 1'b1;
            tries++;
            @(negedge I_sys_clk);
        end
        if (!ex_mem_allowin) begin
            abort_run("timeout waiting for ex_mem_allowin");
        end
        lat = is_load_op(b.mem_op) ? 2 + dmem_read_latency : 2;
        want_q.push_back(model_commit(b)); // taken on the coming rising edge.
        due_q.push_back(timed ? cycle + lat : -1);
        next_cycle();
        ex_mem_valid = 1'b0;
    endtask

    task automatic drain_queue();
        int tries;
        tries = 0;
        while (want_q.size() != 0 && tries < timeout_cycles) begin
            tries++;
            next_cycle();
        end
        if (want_q.size() != 0) begin
            abort_run("timeout waiting for outstanding commits");
        end
    endtask

    task automatic run_result_tests();
        ex_mem_bus_t b;
        for (int i = 0; i < 12; i++) begin
            b = build_item(mem_none, '0, (i % 3 == 2) ? regin_pc4 : regin_alu);
            if (i % 4 == 0) begin
                b.rd_addr = '0;
            end
            b.bubble = (i % 5 == 3);
            drain_queue();
            send_item(b, 1'b1);
        end
    endtask

    task automatic run_load_store_tests();
        ex_mem_bus_t b;
        logic [63:0] base;
        base = 64'h100;
        b    = build_item(mem_sd, base, regin_none);
        drain_queue();
        send_item(b, 1'b1);
        for (int s = 8; s <= 11; s++) begin
            b = build_item(mem_op_e'(4'(s)), base | rand_bits(3), regin_none);
            drain_queue();
            send_item(b, 1'b1);
            for (int l = 1; l <= 7; l++) begin
                b = build_item(mem_op_e'(4'(l)), base | rand_bits(3), regin_mem);
                drain_queue();
                send_item(b, 1'b1);
            end
        end
    endtask

    task automatic run_stall_test();
        ex_mem_bus_t b;
        drain_queue();
        stall_seen = 1'b0;
        for (int i = 0; i < 8; i++) begin
            case (i % 4)
                0:       b = build_item(mem_ld, 64'h100, regin_mem);
                1:       b = build_item(mem_none, '0, regin_alu);
                2:       b = build_item(mem_sw, 64'h108 | rand_bits(3), regin_none);
                default: b = build_item(mem_lhu, 64'h108 | rand_bits(3), regin_mem);
            endcase
            send_item(b, 1'b0); // items follow back to back without a drain.
        end
        drain_queue();
        compare_value("ex_mem_allowin low under a pending load", 64'(stall_seen), 64'd1);
    endtask

    task automatic run_random_traffic(int n);
        logic [1:0] gap;
        for (int i = 0; i < n; i++) begin
            send_item(random_item(), 1'b0);
            gap = 2'(rand_bits(2));
            if (gap[1]) begin
                repeat (int'(gap[0]) + 1) next_cycle();
            end
        end
    endtask

    always @(negedge I_sys_clk) begin : compare_commits
        wb_commit_t want;
        int         due;
        if (!I_rst && commit_valid) begin
            if (want_q.size() == 0) begin
                abort_run("commit seen with no item outstanding");
            end else begin
                want = want_q.pop_front();
                due  = due_q.pop_front();
                compare_value("commit.pc", commit.pc, want.pc);
                compare_value("commit.rd_addr", 64'(commit.rd_addr), 64'(want.rd_addr));
                compare_value("commit.wen", 64'(commit.wen), 64'(want.wen));
                compare_value("commit.wdata", commit.wdata, want.wdata);
                compare_value("commit.inst", 64'(commit.inst), 64'(want.inst));
                if (due >= 0) begin
                    compare_value("commit cycle", 64'(cycle), 64'(due));
                end
            end
        end
    end

    initial begin
        lfsr_state   = 32'hf74e;
        I_sys_clk    = 1'b0;
        I_rst        = 1'b1;
        ex_mem_valid = 1'b0;
        ex_mem_bus   = '0;
        stall_seen   = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (3) @(posedge I_sys_clk);
        #1;
        I_rst = 1'b0;
        @(negedge I_sys_clk);
        compare_value("commit_valid", 64'(commit_valid), 64'd0);
        compare_value("ex_mem_allowin", 64'(ex_mem_allowin), 64'd1);
        next_cycle();
        run_result_tests();
        run_load_store_tests();
        run_stall_test();
        run_random_traffic(400);
        drain_queue();
        $display("Test completed successfully");
        $finish;
    end

endmodule
